// ==== bench/mbist_cfg_tb.sv ====
// -----------------------------------------------
// MBIST config block testbench
// Bus traffic, lane chain model, reference checks
// -----------------------------------------------
`default_nettype none

`include "mbist_cfg_config.svh"

module mbist_cfg_tb;
    import mbist_cfg_pkg::*;

    // Test lengths and watchdog bound
    localparam int N_RW  = 24;
    localparam int N_ST  = 8;
    localparam int N_TXN = 24 + 4 * N_RW + N_ST;

    // Expected register contents
    typedef struct packed {
        logic [31:0] scratch0;
        logic [31:0] scratch1;
        logic [31:0] ctrl;
        logic [31:0] ser_last;
    } shadow_t;

    logic                    mclk;
    logic                    reset_n;
    reg_req_t                reg_req;
    reg_rsp_t                reg_rsp;
    logic [`MBIST_LANES-1:0] bist_en;
    logic [`MBIST_LANES-1:0] bist_run;
    logic [`MBIST_LANES-1:0] bist_load;
    logic [`MBIST_LANES-1:0] bist_sdi;
    logic [`MBIST_LANES-1:0] bist_shift;
    logic [`MBIST_LANES-1:0] bist_sdo;
    bist_stat_in_t           stat_in;
    logic [31:0]             exp_rdata;
    logic [31:0]             chain [`MBIST_LANES];
    int                      shift_cnt [`MBIST_LANES];
    logic [15:0]             lfsr_state = 16'd14251;

    tb_clkgen #(.PERIOD(8), .RST_CYCLES(2)) tb_clkgen_i (.mclk(mclk), .reset_n(reset_n));

    mbist_cfg_top mbist_cfg_top_i (
        .mclk (mclk), .reset_n (reset_n), .reg_req (reg_req), .reg_rsp (reg_rsp),
        .bist_en (bist_en), .bist_run (bist_run), .bist_load (bist_load),
        .bist_sdi (bist_sdi), .bist_shift (bist_shift), .bist_sdo (bist_sdo),
        .stat_in (stat_in)
    );

    // -----------------------------------------------
    // Failure reporting and checks
    // -----------------------------------------------
    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            fail_stop($sformatf("CHECK FAILED time=%0t signal=%s got=%h expected=%h",
                                $time, name, got, exp));
        end
    endtask

    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // Byte-wise update under the enables
    function automatic logic [31:0] merge_be(input logic [31:0] old, input logic [31:0] wdata,
                                             input logic [3:0] be);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) r[b*8 +: 8] = wdata[b*8 +: 8];
        end
        return r;
    endfunction

    // Expected read data of a non-shifting word
    function automatic logic [31:0] ref_rdata(input logic [2:0] word, input shadow_t sh,
                                              input bist_stat_in_t st);
        logic [31:0] r;
        r = '0;
        case (word)
            3'd0: r = sh.scratch0;
            3'd1: r = sh.scratch1;
            3'd2: r = sh.ctrl;
            3'd3: begin
                // Byte per lane: count, zero, correct, error, done
                for (int l = 0; l < `MBIST_LANES; l++) begin
                    r[l*8 +: 8] = {st.err_cnt[l], 1'b0, st.correct[l], st.error[l], st.done[l]};
                end
            end
            3'd6: r = sh.ser_last;
            default: r = '0;
        endcase
        return r;
    endfunction

    // -----------------------------------------------
    // Lane chain model and compare process
    // -----------------------------------------------
    always @(posedge mclk) begin
        for (int l = 0; l < `MBIST_LANES; l++) begin
            if (bist_shift[l] === 1'b1) begin
                chain[l]     <= {bist_sdi[l], chain[l][31:1]};
                shift_cnt[l] <= shift_cnt[l] + 1;
            end
        end
    end

    always_comb begin
        for (int l = 0; l < `MBIST_LANES; l++) bist_sdo[l] = chain[l][0];
    end

    // Every ack checked mid-cycle, where rdata is settled
    always @(negedge mclk) begin
        if (reg_rsp.ack === 1'b1) begin
            assert (reg_rsp.rdata === exp_rdata) else begin
                fail_stop($sformatf("CHECK FAILED time=%0t signal=reg_rsp.rdata got=%h expected=%h",
                                    $time, reg_rsp.rdata, exp_rdata));
            end
        end
    end

    // Watchdog
    initial begin
        repeat (60 * N_TXN + 10) @(posedge mclk);
        fail_stop("Timeout: the test sequence did not finish in time");
    end

    // -----------------------------------------------
    // Bus tasks
    // -----------------------------------------------
    // Starts and ends one cycle past a rising edge
    task automatic bus_access(input logic wr, input logic [2:0] word, input logic [31:0] wdata,
                              input logic [3:0] be, input logic [31:0] exp);
        int   waited;
        logic ser_word;
        waited        = 0;
        ser_word      = (wr && word == `ADDR_SER_WR) || (!wr && word == `ADDR_SER_RD);
        exp_rdata     = exp;
        reg_req.cs    = 1'b1;
        reg_req.wr    = wr;
        reg_req.addr  = {3'b000, word, 2'b00};
        reg_req.wdata = wdata;
        reg_req.be    = be;
        do begin
            @(posedge mclk);
            #1;
            waited++;
            if (waited > 60) fail_stop("No ack from the DUT within 60 cycles");
        end while (reg_rsp.ack !== 1'b1);
        // Plain words ack on the first edge after the request
        if (!ser_word) check_val("ack_latency", 32'(waited), 32'd1);
        reg_req.cs = 1'b0;
        // Idle cycle between requests
        @(posedge mclk);
        #1;
        // Ack lasts a single cycle
        check_val("reg_rsp.ack", 32'(reg_rsp.ack), 32'h0);
    endtask

    // Read back the three plain registers and the lane control outputs
    task automatic check_regs(input shadow_t sh);
        logic [3:0]  en_exp;
        logic [3:0]  run_exp;
        logic [3:0]  load_exp;
        for (int w = 0; w < 3; w++) begin
            bus_access(1'b0, 3'(w), '0, '0, ref_rdata(3'(w), sh, stat_in));
        end
        for (int l = 0; l < `MBIST_LANES; l++) begin
            en_exp[l]   = sh.ctrl[l*4];
            run_exp[l]  = sh.ctrl[l*4+1];
            load_exp[l] = sh.ctrl[l*4+2];
        end
        check_val("bist_en", 32'(bist_en), 32'(en_exp));
        check_val("bist_run", 32'(bist_run), 32'(run_exp));
        check_val("bist_load", 32'(bist_load), 32'(load_exp));
        check_val("bist_shift", 32'(bist_shift), 32'h0);
    endtask

    // -----------------------------------------------
    // Stimulus
    // -----------------------------------------------
    initial begin : stimulus
        shadow_t     sh;
        logic [31:0] data;
        logic [31:0] old;
        logic [3:0]  be;
        logic [2:0]  w;
        reg_req = '0;
        stat_in = '0;
        for (int l = 0; l < `MBIST_LANES; l++) begin
            chain[l]     = lfsr_bits(32);
            shift_cnt[l] = 0;
        end
        sh.scratch0 = `SCRATCH0_RST;
        sh.scratch1 = `SCRATCH1_RST;
        sh.ctrl     = `CTRL_RST;
        sh.ser_last = '0;
        @(posedge reset_n);
        @(posedge mclk);
        #1;

        // Reset values
        check_regs(sh);

        // Random byte-enabled writes
        for (int n = 0; n < N_RW; n++) begin
            w    = 3'(lfsr_bits(2));
            if (w == 3'd3) w = `ADDR_CTRL;
            be   = 4'(lfsr_bits(4));
            data = lfsr_bits(32);
            bus_access(1'b1, w, data, be, 32'h0);
            case (w)
                3'd0:    sh.scratch0 = merge_be(sh.scratch0, data, be);
                3'd1:    sh.scratch1 = merge_be(sh.scratch1, data, be);
                default: sh.ctrl     = merge_be(sh.ctrl, data, be);
            endcase
            check_regs(sh);
        end

        // Status packing, then the zero words
        for (int n = 0; n < N_ST; n++) begin
            stat_in = bist_stat_in_t'(lfsr_bits(28));
            bus_access(1'b0, `ADDR_STATUS, '0, '0, ref_rdata(`ADDR_STATUS, sh, stat_in));
        end
        bus_access(1'b0, 3'd4, '0, '0, 32'h0);
        bus_access(1'b0, 3'd7, '0, '0, 32'h0);

        // Serial load and unload of each lane
        for (int sel = 0; sel <= `MBIST_LANES; sel++) begin
            data = {4'(sel), 28'h0};
            bus_access(1'b1, `ADDR_CTRL, data, 4'b1000, 32'h0);
            sh.ctrl = merge_be(sh.ctrl, data, 4'b1000);
            for (int l = 0; l < `MBIST_LANES; l++) shift_cnt[l] = 0;
            if (sel < `MBIST_LANES) begin
                old  = chain[sel];
                data = lfsr_bits(32);
                bus_access(1'b1, `ADDR_SER_WR, data, 4'hF, 32'h0);
                sh.ser_last = old;
                check_val($sformatf("chain[%0d]", sel), chain[sel], data);
                for (int l = 0; l < `MBIST_LANES; l++) begin
                    check_val($sformatf("shift_cnt[%0d]", l), 32'(shift_cnt[l]),
                              (l == sel) ? 32'd32 : 32'd0);
                end
                old = chain[sel];
            end else begin
                // Fresh lane contents, none of them may reach sdo
                for (int l = 0; l < `MBIST_LANES; l++) chain[l] = lfsr_bits(32);
                // No lane selected, sdo reads as zero
                old = 32'h0;
            end
            bus_access(1'b0, `ADDR_SER_RD, '0, '0, old);
            sh.ser_last = old;
            bus_access(1'b0, `ADDR_SER_LAST, '0, '0, ref_rdata(`ADDR_SER_LAST, sh, stat_in));
            if (sel == `MBIST_LANES) begin
                for (int l = 0; l < `MBIST_LANES; l++) begin
                    check_val($sformatf("shift_cnt[%0d]", l), 32'(shift_cnt[l]), 32'd0);
                end
            end
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/tb_clkgen.sv ====
// -----------------------------------------------
// Testbench clock and reset source
// -----------------------------------------------
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD     = 8,
    parameter int RST_CYCLES = 2
) (
    output logic mclk,
    output logic reset_n
);
    // Free-running clock
    initial mclk = 1'b0;
    always #(PERIOD / 2) mclk = ~mclk;

    // Reset held low for a few edges, released off the edge
    initial begin
        reset_n = 1'b0;
        repeat (RST_CYCLES) @(posedge mclk);
        #1 reset_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+src
src/mbist_cfg_pkg.sv
src/cfg_reg.sv
src/reg_decode.sv
src/bist_serial_shift.sv
src/bist_lane_map.sv
src/mbist_cfg_top.sv
bench/tb_clkgen.sv
bench/mbist_cfg_tb.sv

// ==== src/bist_lane_map.sv ====
// -----------------------------------------------
// Lane steering for the serial link and status word
// -----------------------------------------------
`default_nettype none

`include "mbist_cfg_config.svh"

module bist_lane_map (
    input  mbist_cfg_pkg::bist_ctrl_t     ctrl,
    input  mbist_cfg_pkg::ser_link_t      ser_link,
    output logic                          sdo_mux,
    output logic [`MBIST_LANES-1:0]       bist_sdi,
    output logic [`MBIST_LANES-1:0]       bist_shift,
    output logic [`MBIST_LANES-1:0]       bist_en,
    output logic [`MBIST_LANES-1:0]       bist_run,
    output logic [`MBIST_LANES-1:0]       bist_load,
    input  logic [`MBIST_LANES-1:0]       bist_sdo,
    input  mbist_cfg_pkg::bist_stat_in_t  stat_in,
    output logic [31:0]                   status
);
    import mbist_cfg_pkg::*;

    logic [`MBIST_LANES-1:0]                lane_hit;
    bist_lane_stat_t [`MBIST_LANES-1:0]     lane_stat;

    always_comb begin
        for (int l = 0; l < `MBIST_LANES; l++) begin
            // One-hot lane select, none for values past the last lane
            lane_hit[l]  = (ctrl.ser_sel == 4'(l));
            // Control nibble fan-out
            bist_en[l]   = ctrl.lane[l].en;
            bist_run[l]  = ctrl.lane[l].run;
            bist_load[l] = ctrl.lane[l].load;
            // Status byte packing
            lane_stat[l].err_cnt = stat_in.err_cnt[l];
            lane_stat[l].zero    = 1'b0;
            lane_stat[l].correct = stat_in.correct[l];
            lane_stat[l].error   = stat_in.error[l];
            lane_stat[l].done    = stat_in.done[l];
        end
    end

    // Only the selected lane sees the link
    assign bist_shift = lane_hit & {`MBIST_LANES{ser_link.shift}};
    assign bist_sdi   = lane_hit & {`MBIST_LANES{ser_link.sdi}};
    assign sdo_mux    = |(lane_hit & bist_sdo);

    assign status = lane_stat;

endmodule

`default_nettype wire

// ==== src/bist_serial_shift.sv ====
// -----------------------------------------------
// Serial shift engine for chain load and unload
// -----------------------------------------------
`default_nettype none

`include "mbist_cfg_config.svh"

module bist_serial_shift (
    input  logic                      mclk,
    input  logic                      reset_n,
    input  logic                      start_wr,
    input  logic                      start_rd,
    input  logic [31:0]               wdata,
    output mbist_cfg_pkg::ser_link_t  ser_link,
    input  logic                      sdo,
    output logic [31:0]               rdata,
    output logic                      done
);
    localparam int CNT_W = $clog2(`SER_LEN);

    logic                  busy;
    logic [CNT_W-1:0]      bit_cnt;
    logic                  done_q;
    logic                  start;
    logic [`SER_LEN-1:0]   shift_q;
    logic [`SER_LEN-1:0]   cap_q;

    // Either request runs the same sequence
    assign start = (start_wr | start_rd) & ~busy;

    // -----------------------------------------------
    // Sequence control
    // -----------------------------------------------
    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (start) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end else if (busy) begin
                // Last shift cycle, done follows next cycle
                if (bit_cnt == CNT_W'(`SER_LEN - 1)) begin
                    busy   <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // -----------------------------------------------
    // Data path
    // -----------------------------------------------
    // Outgoing word, LSB first; a read pushes zeros into the chain
    always_ff @(posedge mclk) begin
        if (start) begin
            shift_q <= start_wr ? wdata : '0;
        end else if (busy) begin
            shift_q <= {1'b0, shift_q[`SER_LEN-1:1]};
        end
    end

    // Capture fills from the top so bit i lands at position i
    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            cap_q <= '0;
        end else if (busy) begin
            cap_q <= {sdo, cap_q[`SER_LEN-1:1]};
        end
    end

    // Link is quiet outside the transfer
    assign ser_link.shift = busy;
    assign ser_link.sdi   = busy & shift_q[0];

    assign rdata = cap_q;
    assign done  = done_q;

endmodule

`default_nettype wire

// ==== src/cfg_reg.sv ====
// -----------------------------------------------
// Byte-enabled config register, any 32-bit payload
// -----------------------------------------------
`default_nettype none

module cfg_reg #(
    parameter type      payload_t = logic [31:0],
    parameter payload_t RST_VAL   = '0
) (
    input  logic        mclk,
    input  logic        reset_n,
    input  logic        wr_en,
    input  logic [3:0]  be,
    input  logic [31:0] wdata,
    output payload_t    q
);
    // Flat storage, payload view on the output
    logic [31:0] data_q;

    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            data_q <= RST_VAL;
        end else begin
            // Each lane of the bus updates its own byte
            for (int b = 0; b < 4; b++) begin
                if (wr_en && be[b]) begin
                    data_q[b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    assign q = payload_t'(data_q);

endmodule

`default_nettype wire

// ==== src/mbist_cfg_config.svh ====
// -----------------------------------------------
// MBIST config block constants
// Register map, reset values, lane and chain sizes
// -----------------------------------------------
`ifndef MBIST_CFG_CONFIG_SVH
`define MBIST_CFG_CONFIG_SVH

// Lane count and serial word length
`define MBIST_LANES      4
`define SER_LEN          32

// Word addresses, taken from byte address bits 4:2
`define ADDR_SCRATCH0    3'd0
`define ADDR_SCRATCH1    3'd1
`define ADDR_CTRL        3'd2
`define ADDR_STATUS      3'd3
`define ADDR_SER_WR      3'd4
`define ADDR_SER_RD      3'd5
`define ADDR_SER_LAST    3'd6

// Register reset values
`define SCRATCH0_RST     32'h4433_2211
`define SCRATCH1_RST     32'hDDCC_BBAA
`define CTRL_RST         32'h0000_0000

`endif

// ==== src/mbist_cfg_pkg.sv ====
// -----------------------------------------------
// Shared types of the MBIST config register block
// -----------------------------------------------
`default_nettype none

`include "mbist_cfg_config.svh"

package mbist_cfg_pkg;

    // Register bus request, held by master until ack
    typedef struct packed {
        logic        cs;
        logic        wr;
        logic [7:0]  addr;
        logic [31:0] wdata;
        logic [3:0]  be;
    } reg_req_t;

    // Register bus response
    typedef struct packed {
        logic [31:0] rdata;
        logic        ack;
    } reg_rsp_t;

    // One lane nibble of the control word, en in bit 0
    typedef struct packed {
        logic rsvd;
        logic load;
        logic run;
        logic en;
    } bist_lane_ctrl_t;

    // Control word, lane 0 in the lowest nibble
    typedef struct packed {
        logic [3:0]                              ser_sel;
        logic [11:0]                             rsvd;
        bist_lane_ctrl_t [`MBIST_LANES-1:0]      lane;
    } bist_ctrl_t;

    // One status byte, done in bit 0
    typedef struct packed {
        logic [3:0] err_cnt;
        logic       zero;
        logic       correct;
        logic       error;
        logic       done;
    } bist_lane_stat_t;

    // Raw per-lane status inputs
    typedef struct packed {
        logic [`MBIST_LANES-1:0]            done;
        logic [`MBIST_LANES-1:0]            error;
        logic [`MBIST_LANES-1:0]            correct;
        logic [`MBIST_LANES-1:0][3:0]       err_cnt;
    } bist_stat_in_t;

    // Serial link toward the selected chain
    typedef struct packed {
        logic sdi;
        logic shift;
    } ser_link_t;

endpackage

`default_nettype wire

// ==== src/mbist_cfg_top.sv ====
// -----------------------------------------------
// MBIST config block top level
// Register decode, config regs, serial engine, lanes
// -----------------------------------------------
`default_nettype none

`include "mbist_cfg_config.svh"

module mbist_cfg_top (
    input  logic                          mclk,
    input  logic                          reset_n,
    input  mbist_cfg_pkg::reg_req_t       reg_req,
    output mbist_cfg_pkg::reg_rsp_t       reg_rsp,
    output logic [`MBIST_LANES-1:0]       bist_en,
    output logic [`MBIST_LANES-1:0]       bist_run,
    output logic [`MBIST_LANES-1:0]       bist_load,
    output logic [`MBIST_LANES-1:0]       bist_sdi,
    output logic [`MBIST_LANES-1:0]       bist_shift,
    input  logic [`MBIST_LANES-1:0]       bist_sdo,
    input  mbist_cfg_pkg::bist_stat_in_t  stat_in
);
    import mbist_cfg_pkg::*;

    // Write strobes from the decoder
    logic        wr_scratch0;
    logic        wr_scratch1;
    logic        wr_ctrl;

    // Register contents
    logic [31:0] scratch0;
    logic [31:0] scratch1;
    bist_ctrl_t  ctrl;
    logic [31:0] status;

    // Serial engine handshake and link
    logic        ser_start_wr;
    logic        ser_start_rd;
    logic        ser_done;
    logic [31:0] ser_rdata;
    ser_link_t   ser_link;
    logic        sdo_mux;

    // -----------------------------------------------
    // Bus decode and read mux
    // -----------------------------------------------
    reg_decode reg_decode_i (
        .mclk         (mclk),
        .reset_n      (reset_n),
        .reg_req      (reg_req),
        .reg_rsp      (reg_rsp),
        .wr_scratch0  (wr_scratch0),
        .wr_scratch1  (wr_scratch1),
        .wr_ctrl      (wr_ctrl),
        .scratch0     (scratch0),
        .scratch1     (scratch1),
        .ctrl         (ctrl),
        .status       (status),
        .ser_start_wr (ser_start_wr),
        .ser_start_rd (ser_start_rd),
        .ser_done     (ser_done),
        .ser_rdata    (ser_rdata)
    );

    // -----------------------------------------------
    // Byte-enabled registers
    // -----------------------------------------------
    cfg_reg #(.payload_t(logic [31:0]), .RST_VAL(`SCRATCH0_RST)) scratch0_i (
        .mclk (mclk), .reset_n (reset_n), .wr_en (wr_scratch0),
        .be (reg_req.be), .wdata (reg_req.wdata), .q (scratch0)
    );

    cfg_reg #(.payload_t(logic [31:0]), .RST_VAL(`SCRATCH1_RST)) scratch1_i (
        .mclk (mclk), .reset_n (reset_n), .wr_en (wr_scratch1),
        .be (reg_req.be), .wdata (reg_req.wdata), .q (scratch1)
    );

    // Control word keeps its struct view
    cfg_reg #(.payload_t(bist_ctrl_t), .RST_VAL(bist_ctrl_t'(`CTRL_RST))) ctrl_i (
        .mclk (mclk), .reset_n (reset_n), .wr_en (wr_ctrl),
        .be (reg_req.be), .wdata (reg_req.wdata), .q (ctrl)
    );

    // -----------------------------------------------
    // Serial chain access
    // -----------------------------------------------
    bist_serial_shift bist_serial_shift_i (
        .mclk     (mclk),
        .reset_n  (reset_n),
        .start_wr (ser_start_wr),
        .start_rd (ser_start_rd),
        .wdata    (reg_req.wdata),
        .ser_link (ser_link),
        .sdo      (sdo_mux),
        .rdata    (ser_rdata),
        .done     (ser_done)
    );

    // Lane steering and status packing
    bist_lane_map bist_lane_map_i (
        .ctrl       (ctrl),
        .ser_link   (ser_link),
        .sdo_mux    (sdo_mux),
        .bist_sdi   (bist_sdi),
        .bist_shift (bist_shift),
        .bist_en    (bist_en),
        .bist_run   (bist_run),
        .bist_load  (bist_load),
        .bist_sdo   (bist_sdo),
        .stat_in    (stat_in),
        .status     (status)
    );

endmodule

`default_nettype wire

// ==== src/reg_decode.sv ====
// -----------------------------------------------
// Register bus decoder
// Write strobes, serial starts, read data and ack
// -----------------------------------------------
`default_nettype none

`include "mbist_cfg_config.svh"

module reg_decode (
    input  logic                        mclk,
    input  logic                        reset_n,
    input  mbist_cfg_pkg::reg_req_t     reg_req,
    output mbist_cfg_pkg::reg_rsp_t     reg_rsp,
    output logic                        wr_scratch0,
    output logic                        wr_scratch1,
    output logic                        wr_ctrl,
    input  logic [31:0]                 scratch0,
    input  logic [31:0]                 scratch1,
    input  mbist_cfg_pkg::bist_ctrl_t   ctrl,
    input  logic [31:0]                 status,
    output logic                        ser_start_wr,
    output logic                        ser_start_rd,
    input  logic                        ser_done,
    input  logic [31:0]                 ser_rdata
);
    logic [2:0]  word;
    logic        wr_req;
    logic        rd_req;
    logic        cs_q;
    logic        req_rise;
    logic        ser_acc;
    logic        ack_d;
    logic        ack_q;
    logic [31:0] rd_mux;
    logic [31:0] rdata_q;

    // Word address and access kind
    assign word   = reg_req.addr[4:2];
    assign wr_req = reg_req.cs & reg_req.wr;
    assign rd_req = reg_req.cs & ~reg_req.wr;

    // Request edge, one register stage on cs
    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            cs_q <= 1'b0;
        end else begin
            cs_q <= reg_req.cs;
        end
    end
    assign req_rise = reg_req.cs & ~cs_q;

    // Plain register writes, blocked while ack is out
    assign wr_scratch0 = wr_req & ~ack_q & (word == `ADDR_SCRATCH0);
    assign wr_scratch1 = wr_req & ~ack_q & (word == `ADDR_SCRATCH1);
    assign wr_ctrl     = wr_req & ~ack_q & (word == `ADDR_CTRL);

    // Serial transfers start once per request
    assign ser_start_wr = req_rise & wr_req & (word == `ADDR_SER_WR);
    assign ser_start_rd = req_rise & rd_req & (word == `ADDR_SER_RD);
    assign ser_acc = (wr_req & (word == `ADDR_SER_WR)) | (rd_req & (word == `ADDR_SER_RD));

    // Read data select, word 4 and 7 read zero
    always_comb begin
        case (word)
            `ADDR_SCRATCH0: rd_mux = scratch0;
            `ADDR_SCRATCH1: rd_mux = scratch1;
            `ADDR_CTRL:     rd_mux = ctrl;
            `ADDR_STATUS:   rd_mux = status;
            `ADDR_SER_RD:   rd_mux = ser_rdata;
            `ADDR_SER_LAST: rd_mux = ser_rdata;
            default:        rd_mux = 32'h0;
        endcase
    end

    // Plain access acks at once, serial waits for the engine
    assign ack_d = ~ack_q & (ser_acc ? ser_done : reg_req.cs);

    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= ack_d;
        end
    end

    // Writes return zero
    always_ff @(posedge mclk) begin
        if (ack_d) begin
            rdata_q <= reg_req.wr ? 32'h0 : rd_mux;
        end
    end

    assign reg_rsp.rdata = rdata_q;
    assign reg_rsp.ack   = ack_q;

endmodule

`default_nettype wire
